//--- logic/estimator_consts.svh
`ifndef ESTIMATOR_CONSTS_SVH
`define ESTIMATOR_CONSTS_SVH

// Samples per batch, one recursion pass covers a whole batch
`define BATCH_LEN 8

// Control bits in one downsampled word
`define SAMPLE_BITS 6

// Signed width of accumulators and partial results
`define ACC_WIDTH 16

// Estimate width at the output
`define OUT_WIDTH 14

// Weight of control bit 0, higher bits halve by shift
`define COEF_BASE 512

// Accumulator leak, state loses state>>>DECAY_SHIFT per step
`define DECAY_SHIFT 3

// Scaling of forward plus backward before saturation
`define SUM_SHIFT 2

`endif

//--- logic/estimatorPkg.sv
`include "estimator_consts.svh"

package estimatorPkg;

    // One downsampled word of control bits
    typedef logic [`SAMPLE_BITS-1:0] sampleT;

    // Partial estimate of one recursion
    typedef logic signed [`ACC_WIDTH-1:0] partialT;

    // Position inside a batch
    typedef logic [$clog2(`BATCH_LEN)-1:0] indexT;

    // Read sequencing, aligned with the sample read data
    typedef struct packed {
        logic  batchStart;
        logic  active;
        indexT fwdIndex;
        indexT bwdIndex;
    } readCtlT;

    // One recursion output with its batch position
    typedef struct packed {
        partialT value;
        indexT   index;
        logic    strobe;
    } resultT;

endpackage

//--- logic/batchMemory.sv
`timescale 1ns/10ps
`include "estimator_consts.svh"

module batchMemory
    import estimatorPkg::*;
#(
    parameter type entryT = sampleT
) (
    input  logic                          clkDS,
    input  logic                          writeEn,
    input  logic [$clog2(`BATCH_LEN):0]   writeAddr,
    input  entryT                         writeData,
    input  logic [$clog2(`BATCH_LEN):0]   readAddrA,
    input  logic [$clog2(`BATCH_LEN):0]   readAddrB,
    output entryT                         readDataA,
    output entryT                         readDataB
);

    // Upper address bit selects the bank
    localparam int depth = 2 * `BATCH_LEN;

    entryT storage [depth];

    always_ff @(posedge clkDS) begin
        if (writeEn) begin
            storage[writeAddr] <= writeData;
        end
    end

    // Registered reads, one cycle after the address
    always_ff @(posedge clkDS) begin
        readDataA <= storage[readAddrA];
        readDataB <= storage[readAddrB];
    end

    writeAddrKnown: assert property (
        @(posedge clkDS) writeEn |-> !$isunknown(writeAddr)
    ) else $error("batchMemory write with unknown address");

endmodule

//--- logic/sampleBatcher.sv
`timescale 1ns/10ps
`include "estimator_consts.svh"

module sampleBatcher
    import estimatorPkg::*;
(
    input  logic    clkDS,
    input  logic    rst,
    input  sampleT  sampleIn,
    output sampleT  fwdSample,
    output sampleT  bwdSample,
    output readCtlT readCtl
);

    indexT batchCount;
    indexT reverseIndex;
    logic  writeBank;
    logic  prevReady;
    logic  wrap;

    assign wrap         = (batchCount == indexT'(`BATCH_LEN - 1));
    assign reverseIndex = indexT'(`BATCH_LEN - 1) - batchCount;

    // Position counter and bank toggle
    always_ff @(posedge clkDS, negedge rst) begin
        if (!rst) begin
            batchCount <= '0;
            writeBank  <= 1'b0;
            prevReady  <= 1'b0;
        end else begin
            if (wrap) begin
                batchCount <= '0;
                writeBank  <= ~writeBank;
                // Opposite bank now holds a full batch
                prevReady  <= 1'b1;
            end else begin
                batchCount <= batchCount + 1'b1;
            end
        end
    end

    // Delayed by the read cycle to line up with the sample data
    always_ff @(posedge clkDS, negedge rst) begin
        if (!rst) begin
            readCtl <= '0;
        end else begin
            readCtl.batchStart <= prevReady && (batchCount == '0);
            readCtl.active     <= prevReady;
            readCtl.fwdIndex   <= batchCount;
            readCtl.bwdIndex   <= reverseIndex;
        end
    end

    // Writes go to the current bank, reads come from the other one
    batchMemory #(
        .entryT(sampleT)
    ) sampleStore (
        .clkDS    (clkDS),
        .writeEn  (rst),
        .writeAddr({writeBank, batchCount}),
        .writeData(sampleIn),
        .readAddrA({~writeBank, batchCount}),
        .readAddrB({~writeBank, reverseIndex}),
        .readDataA(fwdSample),
        .readDataB(bwdSample)
    );

    counterInRange: assert property (
        @(posedge clkDS) disable iff (!rst) batchCount < `BATCH_LEN
    ) else $error("batch counter left its range");

endmodule

//--- logic/recursionUnit.sv
`timescale 1ns/10ps
`include "estimator_consts.svh"

module recursionUnit
    import estimatorPkg::*;
(
    input  logic    clkDS,
    input  logic    rst,
    input  sampleT  sample,
    input  readCtlT readCtl,
    output resultT  result
);

    partialT state;
    partialT lutSum;
    partialT nextState;
    indexT   resultIndex;
    logic    resultStrobe;

    // Each bit adds or subtracts its weight
    function automatic partialT coefSum(input sampleT word);
        partialT acc;
        partialT weight;
        acc = '0;
        for (int i = 0; i < `SAMPLE_BITS; i++) begin
            weight = partialT'(`COEF_BASE >> i);
            if (word[i]) begin
                acc = acc + weight;
            end else begin
                acc = acc - weight;
            end
        end
        return acc;
    endfunction

    always_comb begin
        lutSum = coefSum(sample);
        // Restart from zero at the first sample of a pass
        if (readCtl.batchStart) begin
            nextState = lutSum;
        end else begin
            nextState = state - (state >>> `DECAY_SHIFT) + lutSum;
        end
    end

    always_ff @(posedge clkDS, negedge rst) begin
        if (!rst) begin
            state        <= '0;
            resultStrobe <= 1'b0;
        end else begin
            resultStrobe <= readCtl.active;
            if (readCtl.active) begin
                state <= nextState;
            end
        end
    end

    always_ff @(posedge clkDS) begin
        resultIndex <= readCtl.fwdIndex;
    end

    assign result = '{value: state, index: resultIndex, strobe: resultStrobe};

endmodule

//--- logic/resultCombiner.sv
`timescale 1ns/10ps
`include "estimator_consts.svh"

module resultCombiner
    import estimatorPkg::*;
(
    input  logic                  clkDS,
    input  logic                  rst,
    input  resultT                fwdResult,
    input  resultT                bwdResult,
    output logic [`OUT_WIDTH-1:0] out,
    output logic                  valid
);

    localparam int satMax = (1 << (`OUT_WIDTH - 1)) - 1;
    localparam int satMin = -(1 << (`OUT_WIDTH - 1));

    logic resBank;
    logic writeBank;
    logic batchSeen;
    logic readArm;
    logic sumValid;
    partialT fwdRead;
    partialT bwdRead;
    logic signed [`ACC_WIDTH:0] sumQ;
    logic signed [`OUT_WIDTH-1:0] saturated;

    // Forward index 0 opens a new batch in the other bank
    assign writeBank = (fwdResult.strobe && fwdResult.index == '0) ? ~resBank : resBank;

    always_ff @(posedge clkDS, negedge rst) begin
        if (!rst) begin
            resBank   <= 1'b0;
            batchSeen <= 1'b0;
            readArm   <= 1'b0;
            sumValid  <= 1'b0;
            valid     <= 1'b0;
            out       <= '0;
        end else begin
            resBank <= writeBank;
            if (fwdResult.strobe && fwdResult.index == '0) begin
                batchSeen <= 1'b1;
                // Second toggle means the previous bank is complete
                if (batchSeen) begin
                    readArm <= 1'b1;
                end
            end
            sumValid <= readArm;
            valid    <= sumValid;
            // Output stays at zero until the first estimate
            if (sumValid) begin
                out <= {~saturated[`OUT_WIDTH-1], saturated[`OUT_WIDTH-2:0]};
            end else begin
                out <= '0;
            end
        end
    end

    // Both banks read at the same index, so forward k meets backward k
    batchMemory #(
        .entryT(partialT)
    ) fwdStore (
        .clkDS    (clkDS),
        .writeEn  (fwdResult.strobe),
        .writeAddr({writeBank, fwdResult.index}),
        .writeData(fwdResult.value),
        .readAddrA({~writeBank, fwdResult.index}),
        .readAddrB({~writeBank, fwdResult.index}),
        .readDataA(fwdRead),
        .readDataB()
    );

    batchMemory #(
        .entryT(partialT)
    ) bwdStore (
        .clkDS    (clkDS),
        .writeEn  (bwdResult.strobe),
        .writeAddr({writeBank, bwdResult.index}),
        .writeData(bwdResult.value),
        .readAddrA({~writeBank, fwdResult.index}),
        .readAddrB({~writeBank, fwdResult.index}),
        .readDataA(bwdRead),
        .readDataB()
    );

    // One bit wider so the add cannot wrap
    always_ff @(posedge clkDS) begin
        sumQ <= (fwdRead + bwdRead) >>> `SUM_SHIFT;
    end

    always_comb begin
        if (sumQ > satMax) begin
            saturated = `OUT_WIDTH'(satMax);
        end else if (sumQ < satMin) begin
            saturated = `OUT_WIDTH'(satMin);
        end else begin
            saturated = sumQ[`OUT_WIDTH-1:0];
        end
    end

    validHolds: assert property (
        @(posedge clkDS) disable iff (!rst) valid |=> valid
    ) else $error("valid dropped without reset");

endmodule

//--- logic/batchEstimator.sv
`timescale 1ns/10ps
`include "estimator_consts.svh"

module batchEstimator
    import estimatorPkg::*;
(
    input  logic                  clkDS,
    input  logic                  rst,
    input  sampleT                sampleIn,
    output logic [`OUT_WIDTH-1:0] out,
    output logic                  valid
);

    sampleT  fwdSample;
    sampleT  bwdSample;
    readCtlT readCtl;
    readCtlT bwdCtl;
    resultT  fwdResult;
    resultT  bwdResult;

    sampleBatcher batcher (
        .clkDS    (clkDS),
        .rst      (rst),
        .sampleIn (sampleIn),
        .fwdSample(fwdSample),
        .bwdSample(bwdSample),
        .readCtl  (readCtl)
    );

    recursionUnit fwdRecursion (
        .clkDS  (clkDS),
        .rst    (rst),
        .sample (fwdSample),
        .readCtl(readCtl),
        .result (fwdResult)
    );

    // Backward pass tags its results with the reversed index
    assign bwdCtl = '{
        batchStart: readCtl.batchStart,
        active:     readCtl.active,
        fwdIndex:   readCtl.bwdIndex,
        bwdIndex:   readCtl.fwdIndex
    };

    recursionUnit bwdRecursion (
        .clkDS  (clkDS),
        .rst    (rst),
        .sample (bwdSample),
        .readCtl(bwdCtl),
        .result (bwdResult)
    );

    resultCombiner combiner (
        .clkDS    (clkDS),
        .rst      (rst),
        .fwdResult(fwdResult),
        .bwdResult(bwdResult),
        .out      (out),
        .valid    (valid)
    );

endmodule

//--- tb/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    input  logic resetReq,
    output logic clkDS,
    output logic rst
);

    initial begin
        clkDS = 1'b0;
        forever #10 clkDS = ~clkDS;
    end

    // Low for 3 cycles, released on a falling edge, again on each request
    initial begin
        rst = 1'b1;
        #1;
        forever begin
            rst = 1'b0;
            repeat (3) @(posedge clkDS);
            @(negedge clkDS);
            rst = 1'b1;
            @(posedge resetReq);
        end
    end

endmodule

//--- tb/estimatorTb.sv
`timescale 1ns/10ps
`include "estimator_consts.svh"

module estimatorTb
    import estimatorPkg::*;
();

    localparam int latency = 2 * `BATCH_LEN + 4;
    localparam int satMax = (1 << (`OUT_WIDTH - 1)) - 1;
    // Input cycles of all tests including both resets
    localparam int testCycles = 24 + 40 + 32 + 32 + 24 + 27 + 48 + 8;

    logic                  clkDS;
    logic                  rst;
    logic                  resetReq;
    sampleT                sampleIn;
    logic [`OUT_WIDTH-1:0] out;
    logic                  valid;

    string                 testName;
    string                 expectedName;
    logic                  expValid;
    logic [`OUT_WIDTH-1:0] expectedOut;
    int                    acceptCount;
    int                    valueErrors;
    int                    timingErrors;
    int                    otherErrors;
    sampleT                batchWords[$];
    string                 batchNames[$];
    logic [`OUT_WIDTH-1:0] expQ[$];
    string                 nameQ[$];

    clockGen clocks (
        .resetReq(resetReq),
        .clkDS   (clkDS),
        .rst     (rst)
    );

    batchEstimator batchEstimator_inst (
        .clkDS   (clkDS),
        .rst     (rst),
        .sampleIn(sampleIn),
        .out     (out),
        .valid   (valid)
    );

    // Sum of the signed bit weights of one word
    function automatic int lutValue(input sampleT word);
        int acc;
        acc = 0;
        for (int i = 0; i < `SAMPLE_BITS; i++) begin
            acc += word[i] ? (`COEF_BASE >> i) : -(`COEF_BASE >> i);
        end
        return acc;
    endfunction

    // Scale, saturate, then offset binary
    function automatic logic [`OUT_WIDTH-1:0] offsetCode(input int sum);
        int scaled;
        scaled = sum >>> `SUM_SHIFT;
        if (scaled > satMax) begin
            scaled = satMax;
        end else if (scaled < -satMax - 1) begin
            scaled = -satMax - 1;
        end
        return {~scaled[`OUT_WIDTH-1], scaled[`OUT_WIDTH-2:0]};
    endfunction

    // Both passes start from zero, so the first step yields the LUT value
    task automatic modelBatch();
        int fwd[`BATCH_LEN];
        int bwd[`BATCH_LEN];
        int state;
        state = 0;
        for (int k = 0; k < `BATCH_LEN; k++) begin
            state = state - (state >>> `DECAY_SHIFT) + lutValue(batchWords[k]);
            fwd[k] = state;
        end
        state = 0;
        for (int k = `BATCH_LEN - 1; k >= 0; k--) begin
            state = state - (state >>> `DECAY_SHIFT) + lutValue(batchWords[k]);
            bwd[k] = state;
        end
        for (int k = 0; k < `BATCH_LEN; k++) begin
            expQ.push_back(offsetCode(fwd[k] + bwd[k]));
            nameQ.push_back(batchNames[k]);
        end
        batchWords.delete();
        batchNames.delete();
    endtask

    // Expected out and valid for the cycle after each rising edge
    always @(posedge clkDS) begin
        if (!rst) begin
            acceptCount = 0;
            expValid = 1'b0;
            batchWords.delete();
            batchNames.delete();
            expQ.delete();
            nameQ.delete();
        end else begin
            batchWords.push_back(sampleIn);
            batchNames.push_back(testName);
            if (batchWords.size() == `BATCH_LEN) begin
                modelBatch();
            end
            if (acceptCount >= latency) begin
                expValid = 1'b1;
                if (expQ.size() > 0) begin
                    expectedOut = expQ.pop_front();
                    expectedName = nameQ.pop_front();
                end else begin
                    otherErrors++;
                    $display("reference model ran out of expected outputs");
                end
            end
            acceptCount++;
        end
    end

    resetClears: assert property (
        @(posedge clkDS) !rst |-> (valid == 1'b0 && out == '0)
    ) else begin
        otherErrors++;
        $display("valid or out not cleared while reset is low");
    end

    // Before the first estimate the output rests at zero
    outIdle: assert property (
        @(negedge clkDS) !valid |-> out == '0
    ) else begin
        valueErrors++;
        $display("[ERROR] %s out expected 0 actual %h", testName, $sampled(out));
    end

    validTiming: assert property (
        @(negedge clkDS) disable iff (!rst) valid == expValid
    ) else begin
        timingErrors++;
        $display("[ERROR] %s valid expected %0b actual %0b",
                 testName, $sampled(expValid), $sampled(valid));
    end

    outValue: assert property (
        @(negedge clkDS) disable iff (!rst) (valid && expValid) |-> out == expectedOut
    ) else begin
        valueErrors++;
        $display("[ERROR] %s out expected %h actual %h",
                 expectedName, $sampled(expectedOut), $sampled(out));
    end

    task automatic driveWord(input string name, input sampleT word);
        testName = name;
        sampleIn = word;
        @(negedge clkDS);
    endtask

    task automatic driveRandom(input string name, input int count);
        repeat (count) driveWord(name, sampleT'($urandom()));
    endtask

    task automatic driveConstant(input string name, input sampleT word, input int count);
        repeat (count) driveWord(name, word);
    endtask

    task automatic pulseReset();
        resetReq = 1'b1;
        wait (rst === 1'b0);
        wait (rst === 1'b1);
        resetReq = 1'b0;
    endtask

    initial begin
        resetReq = 1'b0;
        sampleIn = '0;
        testName = "reset";
        expectedName = "reset";
        expValid = 1'b0;
        expectedOut = '0;
        acceptCount = 0;
        valueErrors = 0;
        timingErrors = 0;
        otherErrors = 0;
        void'($urandom(32'h206b5823));
        wait (rst === 1'b0);
        wait (rst === 1'b1);
        driveRandom("resetLatency", 24);
        driveRandom("randomWords", 40);
        driveConstant("allOnes", '1, 32);
        driveConstant("allZeros", '0, 32);
        // One set bit per batch at a different position and bit each time
        for (int b = 0; b < 3; b++) begin
            for (int k = 0; k < `BATCH_LEN; k++) begin
                driveWord("singleBit", (k == 3 * b + 1) ? sampleT'(1 << (2 * b)) : '0);
            end
        end
        // Reset lands in the middle of a batch
        driveRandom("midReset", 27);
        pulseReset();
        driveRandom("midReset", 48);
        repeat (2) @(negedge clkDS);
        $display("Summary: %0d value errors, %0d valid timing errors, %0d other errors",
                 valueErrors, timingErrors, otherErrors);
        if (valueErrors + timingErrors + otherErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (testCycles + 4 * `BATCH_LEN) @(posedge clkDS);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
logic/estimatorPkg.sv
logic/batchMemory.sv
logic/sampleBatcher.sv
logic/recursionUnit.sv
logic/resultCombiner.sv
logic/batchEstimator.sv
tb/clockGen.sv
tb/estimatorTb.sv

//--- Bender.yml
package:
  name: batch_estimator

sources:
  - include_dirs:
      - logic
    files:
      - logic/estimatorPkg.sv
      - logic/batchMemory.sv
      - logic/sampleBatcher.sv
      - logic/recursionUnit.sv
      - logic/resultCombiner.sv
      - logic/batchEstimator.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/clockGen.sv
      - tb/estimatorTb.sv
